// ==== hdl/dbgnoc_pkg.sv ====
// debug network flit format
// 16-bit content with a 2-bit type above it, one virtual channel only
// header content is dest | class | source id, msb first
package dbgnoc_pkg;

   // flit content, type and the whole flit
   typedef logic [15:0] flit_data_t;
   typedef logic [1:0]  flit_type_t;
   typedef logic [$bits(flit_type_t)+$bits(flit_data_t)-1:0] flit_t;

   localparam flit_type_t FLIT_PAYLOAD = 2'd0;
   localparam flit_type_t FLIT_HEADER  = 2'd1;
   localparam flit_type_t FLIT_LAST    = 2'd2;

   // header fields
   typedef logic [4:0] ph_dest_t;
   typedef logic [2:0] ph_class_t;
   typedef logic [7:0] ph_id_t;

   // debug host sits at address 0
   localparam ph_dest_t ADDR_EXTERNAL_IF = 5'd0;

   // packet classes
   localparam ph_class_t CLASS_REG_WRITE = 3'd1;
   localparam ph_class_t CLASS_NRM_DATA  = 3'd2;
   localparam ph_class_t CLASS_REG_READ  = 3'd3;
   localparam ph_class_t CLASS_READ_RESP = 3'd4;

   // field access
   function automatic flit_type_t get_type(flit_t f);
      return f[$bits(flit_t)-1 -: $bits(flit_type_t)];
   endfunction

   function automatic flit_data_t get_data(flit_t f);
      return f[$bits(flit_data_t)-1:0];
   endfunction

   function automatic ph_class_t get_class(flit_t f);
      return f[$bits(ph_id_t) +: $bits(ph_class_t)];
   endfunction

   function automatic ph_id_t get_id(flit_t f);
      return f[$bits(ph_id_t)-1:0];
   endfunction

   function automatic flit_data_t make_header(ph_dest_t dest, ph_class_t cls, ph_id_t id);
      return {dest, cls, id};
   endfunction

endpackage

// ==== hdl/nrm_pkg.sv ====
// network router monitor configuration
// trace word is the timestamp on top, then one flit count byte per link,
// link 0 in the lowest byte
// configuration words 0 and 1 are read-only, 2 and 3 read-write
package nrm_pkg;

   // trace format
   localparam int LINK_COUNT  = 4;
   localparam int TS_WIDTH    = 32;
   localparam int TRACE_WIDTH = TS_WIDTH + 8 * LINK_COUNT;
   typedef logic [TRACE_WIDTH-1:0] trace_word_t;

   // two link bytes per data flit, odd counts padded with a zero byte
   localparam int DATA_FLITS         = (LINK_COUNT + 1) / 2;
   localparam int TRACE_PADDED_WIDTH = TS_WIDTH + 16 * DATA_FLITS;
   localparam int PAD_BITS           = TRACE_PADDED_WIDTH - TRACE_WIDTH;
   localparam int DATA_CNT_W         = $clog2(DATA_FLITS + 1);

   // identity
   localparam logic [7:0] ROUTER_ID          = 8'h05;
   localparam logic [7:0] MODULE_TYPE_NRM    = 8'h03;
   localparam logic [7:0] MODULE_VERSION_NRM = 8'h00;

   // configuration memory
   localparam int CONF_MEM_SIZE = 4;
   typedef logic [15:0] conf_addr_t;
   typedef logic [15:0] conf_data_t;
   typedef logic [7:0]  flitcnt_t;

   localparam conf_addr_t CONF_ADDR_TYPE     = 16'd0;
   localparam conf_addr_t CONF_ADDR_ID       = 16'd1;
   localparam conf_addr_t CONF_ADDR_INTERVAL = 16'd2;
   localparam conf_addr_t CONF_ADDR_MINCNT   = 16'd3;

   localparam conf_data_t DEFAULT_SAMPLE_INTERVAL = 16'h0010;
   localparam flitcnt_t   DEFAULT_MIN_FLITCNT     = 8'h04;

   // buffers, flit FIFO holds one whole trace packet
   localparam int TRACE_FIFO_DEPTH = 4;
   localparam int FLIT_FIFO_DEPTH  = 3 + DATA_FLITS;

endpackage

// ==== hdl/flit_fifo.sv ====
// single clock valid/ready FIFO, head slot drives out_data directly
// in_ready drops only when full, no write-through on a full FIFO
// high_water is set at a fill of DEPTH-1 or more
// DEPTH must be 2 or more
module flit_fifo #(
   parameter int WIDTH = 18,
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [WIDTH-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready,
   output logic             high_water
);

   logic [WIDTH-1:0]           mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       push;
   logic                       pop;

   assign in_ready   = (int'(count) != DEPTH);
   assign out_valid  = (count != '0);
   assign out_data   = mem[rd_ptr];
   assign high_water = (int'(count) >= DEPTH - 1);

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   // pointers wrap by hand, DEPTH need not be a power of two
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         // fill count, unchanged on push and pop together
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

endmodule

// ==== hdl/nrm_trace_sender.sv ====
// trace path toward the debug network, plus arbitration of the outgoing link
// a trace word becomes header, timestamp msb, timestamp lsb and the
// link-pair flits, highest pair first, last one typed LAST
// packets are built only into an empty flit FIFO, so one always fits
// configuration responses get the link via rts/cts and win over trace
// sys_clk_disable lags the trace FIFO fill by one cycle; the free slot
// left at DEPTH-1 takes the word that arrives during that cycle
module nrm_trace_sender
   import dbgnoc_pkg::*;
   import nrm_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  trace_word_t trace_in,
   input  logic        trace_valid,
   output logic        sys_clk_disable,
   input  flit_t       conf_flit,
   input  logic        conf_valid,
   input  logic        conf_rts,
   output logic        conf_cts,
   output logic        conf_ready,
   output flit_t       out_flit,
   output logic        out_valid,
   input  logic        out_ready
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CONF,
      ST_HEADER,
      ST_TS_MSB,
      ST_TS_LSB,
      ST_DATA
   } state_t;

   state_t state;
   state_t state_next;

   // trace FIFO head
   trace_word_t trace_head;
   logic        trace_avail;
   logic        trace_pop;
   logic        trace_high_water;

   // packetizer into the flit FIFO
   flit_t pk_flit;
   logic  pk_valid;
   logic  pk_ready;

   // flit FIFO toward the link
   flit_t fifo_flit;
   logic  fifo_valid;
   logic  fifo_ready;

   // word being packed and remaining data flits
   trace_word_t                   word_buf;
   logic [TRACE_PADDED_WIDTH-1:0] word_padded;
   logic [DATA_CNT_W-1:0]         data_cnt;
   logic                          cnt_load;
   logic                          cnt_dec;

   flit_fifo #(
      .WIDTH(TRACE_WIDTH),
      .DEPTH(TRACE_FIFO_DEPTH)
   ) u_trace_fifo (
      .clk        (clk),
      .rst        (rst),
      .in_data    (trace_in),
      .in_valid   (trace_valid),
      .in_ready   (),
      .out_data   (trace_head),
      .out_valid  (trace_avail),
      .out_ready  (trace_pop),
      .high_water (trace_high_water)
   );

   flit_fifo #(
      .WIDTH($bits(flit_t)),
      .DEPTH(FLIT_FIFO_DEPTH)
   ) u_flit_fifo (
      .clk        (clk),
      .rst        (rst),
      .in_data    (pk_flit),
      .in_valid   (pk_valid),
      .in_ready   (pk_ready),
      .out_data   (fifo_flit),
      .out_valid  (fifo_valid),
      .out_ready  (fifo_ready),
      .high_water ()
   );

   // odd link count gets a zero byte below link 0
   if (PAD_BITS == 0) begin : g_no_pad
      assign word_padded = word_buf;
   end else begin : g_pad
      assign word_padded = {word_buf, {PAD_BITS{1'b0}}};
   end

   // link owner, grant is a pure decode of the state
   assign conf_cts   = (state == ST_CONF);
   assign conf_ready = conf_cts & out_ready;
   assign fifo_ready = ~conf_cts & out_ready;
   assign out_valid  = conf_cts ? conf_valid : fifo_valid;
   assign out_flit   = conf_cts ? conf_flit : fifo_flit;

   always_comb begin
      state_next = state;
      pk_valid   = 1'b0;
      pk_flit    = '0;
      trace_pop  = 1'b0;
      cnt_load   = 1'b0;
      cnt_dec    = 1'b0;
      case (state)
         ST_IDLE: begin
            // previous packet must be fully out first
            if (!fifo_valid) begin
               if (conf_rts) begin
                  state_next = ST_CONF;
               end else if (trace_avail) begin
                  trace_pop  = 1'b1;
                  state_next = ST_HEADER;
               end
            end
         end
         ST_CONF: begin
            // hold the grant until the response is through
            if (!conf_rts && !conf_valid) begin
               state_next = ST_IDLE;
            end
         end
         ST_HEADER: begin
            pk_valid = 1'b1;
            pk_flit  = {FLIT_HEADER, make_header(ADDR_EXTERNAL_IF, CLASS_NRM_DATA, ROUTER_ID)};
            cnt_load = pk_ready;
            if (pk_ready) begin
               state_next = ST_TS_MSB;
            end
         end
         ST_TS_MSB: begin
            pk_valid = 1'b1;
            pk_flit  = {FLIT_PAYLOAD, word_padded[TRACE_PADDED_WIDTH-1 -: 16]};
            if (pk_ready) begin
               state_next = ST_TS_LSB;
            end
         end
         ST_TS_LSB: begin
            pk_valid = 1'b1;
            pk_flit  = {FLIT_PAYLOAD, word_padded[TRACE_PADDED_WIDTH-17 -: 16]};
            if (pk_ready) begin
               state_next = ST_DATA;
            end
         end
         ST_DATA: begin
            pk_valid = 1'b1;
            // link pairs from the top down, count 0 is the last flit
            pk_flit  = {(data_cnt == '0) ? FLIT_LAST : FLIT_PAYLOAD,
                        word_padded[int'(data_cnt)*16 +: 16]};
            if (pk_ready) begin
               if (data_cnt == '0) begin
                  state_next = ST_IDLE;
               end else begin
                  cnt_dec = 1'b1;
               end
            end
         end
         default: state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state           <= ST_IDLE;
         sys_clk_disable <= 1'b0;
      end else begin
         state           <= state_next;
         sys_clk_disable <= trace_high_water;
      end
   end

   // packed word and flit counter, loaded before use
   always_ff @(posedge clk) begin
      if (trace_pop) begin
         word_buf <= trace_head;
      end
      if (cnt_load) begin
         data_cnt <= DATA_CNT_W'(DATA_FLITS - 1);
      end else if (cnt_dec) begin
         data_cnt <= data_cnt - 1'b1;
      end
   end

endmodule

// ==== hdl/dbgnoc_conf_if.sv ====
// register access over the debug network
// write packet is header, address, data (LAST); read is header, address (LAST)
// read response is header, address, data (LAST), sent back to the source id
// one response in flight; a second read stalls at its address flit
// unknown classes and malformed packets are consumed up to their LAST flit
module dbgnoc_conf_if
   import dbgnoc_pkg::*;
   import nrm_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  flit_t      in_flit,
   input  logic       in_valid,
   output logic       in_ready,
   output flit_t      conf_flit,
   output logic       conf_valid,
   output logic       conf_rts,
   input  logic       conf_cts,
   input  logic       conf_ready,
   output conf_data_t sample_interval,
   output flitcnt_t   min_flitcnt
);

   typedef enum logic [1:0] {RX_HEAD, RX_ADDR, RX_DATA, RX_SKIP} rx_state_t;
   typedef enum logic [1:0] {TX_IDLE, TX_HEAD, TX_ADDR, TX_DATA} tx_state_t;

   rx_state_t rx_state;
   tx_state_t tx_state;

   // receive side
   logic       rx_take;
   logic       rx_last;
   ph_class_t  rx_class;
   ph_id_t     rx_src;
   conf_addr_t rx_addr;

   // memory read port, addressed straight from the incoming flit
   conf_addr_t rd_addr;
   conf_data_t rd_data;

   // captured response
   logic       resp_load;
   ph_id_t     resp_dest;
   conf_addr_t resp_addr;
   conf_data_t resp_data;
   logic       tx_take;

   assign in_ready  = !(rx_state == RX_ADDR && rx_class == CLASS_REG_READ &&
                        tx_state != TX_IDLE);
   assign rx_take   = in_valid & in_ready;
   assign rx_last   = (get_type(in_flit) == FLIT_LAST);
   assign rd_addr   = get_data(in_flit);
   assign resp_load = rx_take && rx_state == RX_ADDR && rx_class == CLASS_REG_READ;

   always_comb begin
      rd_data = '0;
      // beyond the memory reads as zero
      if (rd_addr < conf_addr_t'(CONF_MEM_SIZE)) begin
         case (rd_addr)
            CONF_ADDR_TYPE:     rd_data = {MODULE_TYPE_NRM, MODULE_VERSION_NRM};
            CONF_ADDR_ID:       rd_data = {8'h00, ROUTER_ID};
            CONF_ADDR_INTERVAL: rd_data = sample_interval;
            CONF_ADDR_MINCNT:   rd_data = {8'h00, min_flitcnt};
            default:            rd_data = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rx_state        <= RX_HEAD;
         sample_interval <= DEFAULT_SAMPLE_INTERVAL;
         min_flitcnt     <= DEFAULT_MIN_FLITCNT;
      end else if (rx_take) begin
         case (rx_state)
            RX_HEAD: begin
               // stray payload outside a packet is dropped here
               if (get_type(in_flit) == FLIT_HEADER) begin
                  if (get_class(in_flit) == CLASS_REG_WRITE ||
                      get_class(in_flit) == CLASS_REG_READ) begin
                     rx_state <= RX_ADDR;
                  end else begin
                     rx_state <= RX_SKIP;
                  end
               end
            end
            RX_ADDR: begin
               if (rx_last) begin
                  rx_state <= RX_HEAD;
               end else if (rx_class == CLASS_REG_WRITE) begin
                  rx_state <= RX_DATA;
               end else begin
                  rx_state <= RX_SKIP;
               end
            end
            RX_DATA: begin
               // only words 2 and 3 take writes
               if (rx_addr == CONF_ADDR_INTERVAL) begin
                  sample_interval <= get_data(in_flit);
               end
               if (rx_addr == CONF_ADDR_MINCNT) begin
                  min_flitcnt <= in_flit[7:0];
               end
               rx_state <= rx_last ? RX_HEAD : RX_SKIP;
            end
            default: begin
               if (rx_last) begin
                  rx_state <= RX_HEAD;
               end
            end
         endcase
      end
   end

   // header fields, write address and response payload
   always_ff @(posedge clk) begin
      if (rx_take && rx_state == RX_HEAD) begin
         rx_class <= get_class(in_flit);
         rx_src   <= get_id(in_flit);
      end
      if (rx_take && rx_state == RX_ADDR) begin
         rx_addr <= rd_addr;
      end
      if (resp_load) begin
         resp_dest <= rx_src;
         resp_addr <= rd_addr;
         resp_data <= rd_data;
      end
   end

   // send side, flits go out only while granted
   assign conf_rts   = (tx_state != TX_IDLE);
   assign conf_valid = conf_rts & conf_cts;
   assign tx_take    = conf_valid & conf_ready;

   always_comb begin
      case (tx_state)
         TX_HEAD: conf_flit = {FLIT_HEADER,
                               make_header(ph_dest_t'(resp_dest), CLASS_READ_RESP, ROUTER_ID)};
         TX_ADDR: conf_flit = {FLIT_PAYLOAD, resp_addr};
         default: conf_flit = {FLIT_LAST, resp_data};
      endcase
   end

   // resp_load only happens while idle, in_ready holds off the rest
   always_ff @(posedge clk) begin
      if (rst) begin
         tx_state <= TX_IDLE;
      end else if (resp_load) begin
         tx_state <= TX_HEAD;
      end else if (tx_take) begin
         case (tx_state)
            TX_HEAD: tx_state <= TX_ADDR;
            TX_ADDR: tx_state <= TX_DATA;
            default: tx_state <= TX_IDLE;
         endcase
      end
   end

endmodule

// ==== hdl/nrm_dbgnoc_if.sv ====
// debug network interface of the router monitor
// trace words in, trace and read response packets out on one link,
// register packets in; single virtual channel
// trace source must pause while sys_clk_disable is high
module nrm_dbgnoc_if
   import dbgnoc_pkg::*;
   import nrm_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  trace_word_t trace_in,
   input  logic        trace_valid,
   output logic        sys_clk_disable,
   output flit_t       out_flit,
   output logic        out_valid,
   input  logic        out_ready,
   input  flit_t       in_flit,
   input  logic        in_valid,
   output logic        in_ready,
   output conf_data_t  sample_interval,
   output flitcnt_t    min_flitcnt
);

   // response path from the register side to the link arbiter
   flit_t conf_flit;
   logic  conf_valid;
   logic  conf_rts;
   logic  conf_cts;
   logic  conf_ready;

   nrm_trace_sender u_trace_sender (
      .clk             (clk),
      .rst             (rst),
      .trace_in        (trace_in),
      .trace_valid     (trace_valid),
      .sys_clk_disable (sys_clk_disable),
      .conf_flit       (conf_flit),
      .conf_valid      (conf_valid),
      .conf_rts        (conf_rts),
      .conf_cts        (conf_cts),
      .conf_ready      (conf_ready),
      .out_flit        (out_flit),
      .out_valid       (out_valid),
      .out_ready       (out_ready)
   );

   dbgnoc_conf_if u_conf_if (
      .clk             (clk),
      .rst             (rst),
      .in_flit         (in_flit),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .conf_flit       (conf_flit),
      .conf_valid      (conf_valid),
      .conf_rts        (conf_rts),
      .conf_cts        (conf_cts),
      .conf_ready      (conf_ready),
      .sample_interval (sample_interval),
      .min_flitcnt     (min_flitcnt)
   );

endmodule

// ==== test/nrm_checker.sv ====
// scoreboard for the debug network interface
// samples all ports on the rising edge, stimulus moves on the falling edge
// expected flits are built from the trace words and register packets it
// sees accepted; responses come back in request order
// assumes well formed register packets on the incoming link
module nrm_checker
   import dbgnoc_pkg::*;
   import nrm_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  trace_word_t trace_in,
   input  logic        trace_valid,
   input  logic        sys_clk_disable,
   input  flit_t       out_flit,
   input  logic        out_valid,
   input  logic        out_ready,
   input  flit_t       in_flit,
   input  logic        in_valid,
   input  logic        in_ready,
   input  conf_data_t  sample_interval,
   input  flitcnt_t    min_flitcnt,
   input  logic        report_req,
   output logic        drained,
   output logic        report_done,
   output int          tests_failed,
   output int          error_count
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int T_RESET = 0;
   localparam int T_TRACE = 1;
   localparam int T_WRITE = 2;
   localparam int T_READ  = 3;
   localparam int T_FRAME = 4;

   string test_name [5] = '{"reset_state", "trace_packet", "reg_write", "reg_read",
                            "no_interleave"};
   int    checks [5];
   int    errors [5];

   // expected outgoing flits, trace and read responses apart
   flit_t trace_q [$];
   flit_t resp_q [$];
   flit_t exp_flit;

   // register model, only words 2 and 3 can change
   logic [15:0] m_interval;
   logic [7:0]  m_mincnt;

   // incoming packet position, 1 = address next, 2 = data next
   int          rx_pos;
   logic [2:0]  rx_cls;
   logic [4:0]  rx_src;
   logic [15:0] rx_addr;

   logic in_pkt;
   logic cur_resp;
   logic rst_d;
   logic write_done;

   task automatic check_value(input int t, input logic [17:0] exp, input logic [17:0] act);
      checks[t]++;
      if (exp !== act) begin
         errors[t]++;
         $display("[ERROR] %s: expected 0x%05h, actual 0x%05h at %0t",
                  test_name[t], exp, act, $time);
      end
   endtask

   task automatic report_problem(input int t, input string what);
      checks[t]++;
      errors[t]++;
      $display("%s failed: %s at %0t", test_name[t], what, $time);
   endtask

   // word contents by address, per the memory map
   function automatic logic [15:0] model_word(input logic [15:0] addr);
      case (addr)
         16'd0:   return 16'h0300;
         16'd1:   return 16'h0005;
         16'd2:   return m_interval;
         16'd3:   return {8'h00, m_mincnt};
         default: return 16'h0000;
      endcase
   endfunction

   always @(posedge clk) begin
      if (rst) begin
         m_interval   = 16'h0010;
         m_mincnt     = 8'h04;
         rx_pos       = 0;
         in_pkt       = 1'b0;
         cur_resp     = 1'b0;
         write_done   = 1'b0;
         report_done  = 1'b0;
         tests_failed = 0;
         error_count  = 0;
         trace_q.delete();
         resp_q.delete();
      end else begin
         // first cycle out of reset
         if (rst_d) begin
            check_value(T_RESET, 18'(1'b0), 18'(out_valid));
            check_value(T_RESET, 18'(1'b0), 18'(sys_clk_disable));
            check_value(T_RESET, 18'(1'b1), 18'(in_ready));
            check_value(T_RESET, 18'(16'h0010), 18'(sample_interval));
            check_value(T_RESET, 18'(8'h04), 18'(min_flitcnt));
            $display("%s: %s", test_name[T_RESET], (errors[T_RESET] == 0) ? "PASS" : "FAIL");
         end
         // register outputs settle one cycle after the write ends
         if (write_done) begin
            check_value(T_WRITE, 18'(m_interval), 18'(sample_interval));
            check_value(T_WRITE, 18'(m_mincnt), 18'(min_flitcnt));
            write_done = 1'b0;
         end
         // trace word taken: header, ts high, ts low, links 3:2, links 1:0
         if (trace_valid) begin
            trace_q.push_back({2'b01, 5'd0, 3'd2, 8'h05});
            trace_q.push_back({2'b00, trace_in[63:48]});
            trace_q.push_back({2'b00, trace_in[47:32]});
            trace_q.push_back({2'b00, trace_in[31:16]});
            trace_q.push_back({2'b10, trace_in[15:0]});
         end
         if (in_valid && in_ready) begin
            if (in_flit[17:16] == 2'b01) begin
               rx_cls = in_flit[10:8];
               rx_src = in_flit[4:0];
               rx_pos = 1;
            end else if (rx_pos == 1) begin
               rx_addr = in_flit[15:0];
               rx_pos  = 2;
               // read: response goes back to the requester
               if (rx_cls == 3'd3) begin
                  resp_q.push_back({2'b01, rx_src, 3'd4, 8'h05});
                  resp_q.push_back({2'b00, rx_addr});
                  resp_q.push_back({2'b10, model_word(rx_addr)});
                  rx_pos = 0;
               end
            end else if (rx_pos == 2 && rx_cls == 3'd1) begin
               if (rx_addr == 16'd2) begin
                  m_interval = in_flit[15:0];
               end
               if (rx_addr == 16'd3) begin
                  m_mincnt = in_flit[7:0];
               end
               write_done = 1'b1;
               rx_pos     = 0;
            end
         end
         // outgoing link, reassemble and compare flit by flit
         if (out_valid && out_ready) begin
            if (out_flit[17:16] == 2'b01) begin
               checks[T_FRAME]++;
               if (in_pkt) begin
                  report_problem(T_FRAME, "header arrived inside an open packet");
               end
               in_pkt   = 1'b1;
               cur_resp = (out_flit[10:8] == 3'd4);
            end else if (!in_pkt) begin
               report_problem(T_FRAME, "payload flit outside any packet");
            end
            if (in_pkt && cur_resp) begin
               if (resp_q.size() == 0) begin
                  report_problem(T_READ, "response flit with no read outstanding");
               end else begin
                  exp_flit = resp_q.pop_front();
                  check_value(T_READ, exp_flit, out_flit);
               end
            end else if (in_pkt) begin
               if (trace_q.size() == 0) begin
                  report_problem(T_TRACE, "trace flit with no word accepted");
               end else begin
                  exp_flit = trace_q.pop_front();
                  check_value(T_TRACE, exp_flit, out_flit);
               end
            end
            if (out_flit[17:16] == 2'b10) begin
               in_pkt = 1'b0;
            end
         end
         if (report_req && !report_done) begin
            for (int t = 1; t < 5; t++) begin
               $display("%s: %s, %0d checks, %0d errors", test_name[t],
                        (errors[t] == 0 && checks[t] > 0) ? "PASS" : "FAIL",
                        checks[t], errors[t]);
            end
            for (int t = 0; t < 5; t++) begin
               error_count += errors[t];
               if (errors[t] != 0 || checks[t] == 0) begin
                  tests_failed++;
               end
            end
            report_done = 1'b1;
         end
      end
      drained = (trace_q.size() == 0) && (resp_q.size() == 0) && !in_pkt && !write_done;
      rst_d   = rst;
   end

endmodule

// ==== test/nrm_assertions.sv ====
// link handshake and packet framing checks, bound into the top level
// framing state starts outside a packet after reset
module nrm_assertions
   import dbgnoc_pkg::*;
(
   input logic  clk,
   input logic  rst,
   input flit_t out_flit,
   input logic  out_valid,
   input logic  out_ready,
   input logic  conf_rts,
   input logic  conf_cts,
   input logic  conf_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   int   fail_count = 0;
   logic in_packet;
   logic out_take;

   assign out_take = out_valid & out_ready;

   // open from a transferred header until a LAST flit
   always_ff @(posedge clk) begin
      if (rst) begin
         in_packet <= 1'b0;
      end else if (out_take) begin
         in_packet <= (out_flit[17:16] != 2'b10);
      end
   end

   // stalled flit stays on the link unchanged
   a_out_hold: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_flit))
      else begin
         $error("outgoing flit dropped or changed while stalled");
         fail_count++;
      end

   a_frame_start: assert property (@(posedge clk) disable iff (rst)
      out_take && !in_packet |-> out_flit[17:16] == 2'b01)
      else begin
         $error("packet on the outgoing link does not start with a header");
         fail_count++;
      end

   a_frame_inside: assert property (@(posedge clk) disable iff (rst)
      out_take && in_packet |-> out_flit[17:16] != 2'b01)
      else begin
         $error("header transferred inside an open packet");
         fail_count++;
      end

   // grant only follows a pending request
   a_grant: assert property (@(posedge clk) disable iff (rst)
      $rose(conf_cts) |-> $past(conf_rts))
      else begin
         $error("link granted to the register side without a request");
         fail_count++;
      end

   // request held until the response's LAST flit is on the link
   a_rts_hold: assert property (@(posedge clk) disable iff (rst)
      conf_rts && !(conf_valid && out_take && out_flit[17:16] == 2'b10) |=> conf_rts)
      else begin
         $error("response request dropped before its last flit transferred");
         fail_count++;
      end

endmodule

bind nrm_dbgnoc_if nrm_assertions u_nrm_assertions (
   .clk        (clk),
   .rst        (rst),
   .out_flit   (out_flit),
   .out_valid  (out_valid),
   .out_ready  (out_ready),
   .conf_rts   (conf_rts),
   .conf_cts   (conf_cts),
   .conf_valid (conf_valid)
);

// ==== test/tb_nrm_dbgnoc_if.sv ====
// testbench top for the router monitor debug network interface
// random trace words, register packets and link back-pressure from one seed
// the trace source pauses while sys_clk_disable is high, as the DUT expects
// register packets are sent one at a time with random gaps
module tb_nrm_dbgnoc_if
   import dbgnoc_pkg::*;
   import nrm_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_OPS    = 150;
   localparam int NUM_TESTS  = 5;
   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 10;

   logic        clk;
   logic        rst;
   trace_word_t trace_in;
   logic        trace_valid;
   logic        sys_clk_disable;
   flit_t       out_flit;
   logic        out_valid;
   logic        out_ready;
   flit_t       in_flit;
   logic        in_valid;
   logic        in_ready;
   conf_data_t  sample_interval;
   flitcnt_t    min_flitcnt;

   integer seed = 32'hb364_4184;
   logic   trace_on;
   logic   report_req;
   logic   drained;
   logic   report_done;
   int     tests_failed;
   int     error_count;
   int     total_errors;

   nrm_dbgnoc_if u_nrm_dbgnoc_if (
      .clk             (clk),
      .rst             (rst),
      .trace_in        (trace_in),
      .trace_valid     (trace_valid),
      .sys_clk_disable (sys_clk_disable),
      .out_flit        (out_flit),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .in_flit         (in_flit),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .sample_interval (sample_interval),
      .min_flitcnt     (min_flitcnt)
   );

   nrm_checker u_checker (
      .clk             (clk),
      .rst             (rst),
      .trace_in        (trace_in),
      .trace_valid     (trace_valid),
      .sys_clk_disable (sys_clk_disable),
      .out_flit        (out_flit),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .in_flit         (in_flit),
      .in_valid        (in_valid),
      .in_ready        (in_ready),
      .sample_interval (sample_interval),
      .min_flitcnt     (min_flitcnt),
      .report_req      (report_req),
      .drained         (drained),
      .report_done     (report_done),
      .tests_failed    (tests_failed),
      .error_count     (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // one flit on the incoming link, in_ready is registered so it is
   // already settled on the falling edge
   task automatic send_flit(input flit_t f);
      logic taken;
      in_flit  = f;
      in_valid = 1'b1;
      taken    = 1'b0;
      while (!taken) begin
         taken = in_ready;
         @(negedge clk);
      end
   endtask

   // random read or write to word 0..5, source id kept to 5 bits
   task automatic run_reg_op();
      logic [31:0] r;
      logic [31:0] d;
      conf_addr_t  addr;
      r    = $random(seed);
      d    = $random(seed);
      addr = r[15:0] % 16'd6;
      if (r[31]) begin
         send_flit({2'b01, 5'd1, 3'd1, 3'b000, r[20:16]});
         send_flit({2'b00, addr});
         send_flit({2'b10, d[15:0]});
      end else begin
         send_flit({2'b01, 5'd1, 3'd3, 3'b000, r[20:16]});
         send_flit({2'b10, addr});
      end
      in_valid = 1'b0;
      repeat (r[24:22]) @(negedge clk);
   endtask

   // trace words and out_ready, new values every falling edge
   initial begin : link_driver
      logic [31:0] r;
      logic [2:0]  density;
      trace_in    = '0;
      trace_valid = 1'b0;
      out_ready   = 1'b0;
      density     = 3'd2;
      forever begin
         @(negedge clk);
         r = $random(seed);
         // trace load shifts now and then
         if (r[31:26] == 6'd0) begin
            density = r[2:0];
         end
         out_ready   = (r[9:8] != 2'b00);
         trace_valid = trace_on && !sys_clk_disable && (r[6:4] < density);
         trace_in    = {$random(seed), $random(seed)};
      end
   end

   initial begin : main
      rst        = 1'b1;
      in_flit    = '0;
      in_valid   = 1'b0;
      trace_on   = 1'b0;
      report_req = 1'b0;
      repeat (RST_CYCLES) @(negedge clk);
      rst      = 1'b0;
      trace_on = 1'b1;
      for (int i = 0; i < NUM_OPS; i++) begin
         run_reg_op();
      end
      trace_on = 1'b0;
      // let the last accepted word reach the scoreboard
      repeat (2) @(negedge clk);
      while (!drained) begin
         @(negedge clk);
      end
      report_req = 1'b1;
      wait (report_done);
      total_errors = error_count + u_nrm_dbgnoc_if.u_nrm_assertions.fail_count;
      $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, tests_failed, total_errors);
      if (tests_failed == 0 && total_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin : watchdog
      #(NUM_OPS * 40 * CLK_PERIOD);
      $display("watchdog expired, packets still outstanding or the DUT stalled");
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== files.f ====
hdl/dbgnoc_pkg.sv
hdl/nrm_pkg.sv
hdl/flit_fifo.sv
hdl/nrm_trace_sender.sv
hdl/dbgnoc_conf_if.sv
hdl/nrm_dbgnoc_if.sv
test/nrm_checker.sv
test/nrm_assertions.sv
test/tb_nrm_dbgnoc_if.sv

// ==== Makefile ====
TOP := tb_nrm_dbgnoc_if

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
